//--- stm.f
logic/stm_pkg.sv
logic/stm_memory.sv
logic/stm_sampler.sv
logic/stm_gain_operator.sv
logic/stm_focus_operator.sv
logic/stm_operator.sv
verification/stm_checker.sv
verification/stm_operator_tb.sv

//--- Makefile
# Verilator build and run of the STM engine testbench.
# Any variable can be overridden, for example: make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= stm_operator_tb
FILELIST  ?= stm.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= SIMULATION PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/stm_operator_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the STM engine. Loads both banks from an LFSR,
// fires update bursts in each mode and reports error counts.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
module stm_operator_tb
  import stm_pkg::*;
();

  localparam int CLK_PERIOD       = 8;
  localparam int FREQ_DIV         = 37;
  localparam int CYCLE            = 20;
  localparam int SPEED            = 347;
  localparam int CYCLES_PER_TRANS = DIST_W + 2;   // Read, root steps and emit.
  localparam int BURST_LIMIT      = NUM_TRANS * CYCLES_PER_TRANS + 8;
  localparam int QUIET_GAP        = NUM_TRANS * CYCLES_PER_TRANS + 8;
  localparam int NUM_BURSTS       = 10;
  localparam int IDX_WAITS        = 4;
  localparam int WATCHDOG_CYCLES  = GAIN_WORDS + FOCUS_DEPTH + 4
                                  + (NUM_BURSTS + 1) * (BURST_LIMIT + QUIET_GAP + 2)
                                  + IDX_WAITS * CYCLE * FREQ_DIV + 2 * FREQ_DIV + 100;

  logic             clk = 1'b0;
  logic             rst_n;
  host_wr_t         host_wr;
  stm_cfg_t         cfg;
  stm_mode_e        mode;
  logic             update;
  drive_t           dout;
  logic             dout_valid;
  logic [IDX_W-1:0] idx;

  gain_word_t  gain_copy  [GAIN_WORDS];    // Bank contents as the host wrote them.
  focus_word_t focus_copy [FOCUS_DEPTH];
  logic [15:0] lfsr_q;
  string       test_name;
  int unsigned timeout_errors;

  always #(CLK_PERIOD / 2) clk = ~clk;

  stm_operator stm_operator_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .host_wr    (host_wr),
    .cfg        (cfg),
    .mode       (mode),
    .update     (update),
    .dout       (dout),
    .dout_valid (dout_valid),
    .idx        (idx)
  );

  stm_checker stm_checker_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .mode       (mode),
    .update     (update),
    .cfg        (cfg),
    .dout       (dout),
    .dout_valid (dout_valid),
    .idx        (idx)
  );

  // ~~~ Stimulus helpers ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Taps 16, 14, 13 and 11 give a maximal length sequence.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int nbits, output logic [DATA_W-1:0] val);
    val = '0;
    for (int b = 0; b < nbits; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[DATA_W-2:0], lfsr_q[0]};
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;                                       // Inputs change just after the edge.
  endtask

  task automatic write_word(input stm_mode_e bank, input int addr,
                            input logic [DATA_W-1:0] data);
    host_wr = '{wr: 1'b1, bank: bank, addr: ADDR_W'(addr), data: data};
    step();
    host_wr.wr = 1'b0;
  endtask

  task automatic load_gain(input int addr);
    logic [DATA_W-1:0] bits;
    draw_bits($bits(gain_word_t), bits);
    gain_copy[addr] = gain_word_t'(bits[$bits(gain_word_t)-1:0]);
    write_word(MODE_GAIN, addr, bits);
  endtask

  task automatic load_focus(input int addr);
    logic [DATA_W-1:0] bits;
    draw_bits($bits(focus_word_t), bits);
    focus_copy[addr] = focus_word_t'(bits[$bits(focus_word_t)-1:0]);
    write_word(MODE_FOCUS, addr, bits);
  endtask

  task automatic wait_for_idx(input int target);
    while (idx != IDX_W'(target)) begin
      step();
    end
  endtask

  // Fires one update and collects all strobes of the selected generator.
  task automatic run_burst(input stm_mode_e m, input string name);
    int strobes;
    int waited;
    test_name = name;
    mode      = m;
    update    = 1'b1;
    step();
    update    = 1'b0;
    strobes   = 0;
    waited    = 0;
    while (strobes < NUM_TRANS && waited < BURST_LIMIT) begin
      step();
      waited++;
      if (dout_valid) begin
        strobes++;
      end
    end
    if (strobes < NUM_TRANS) begin
      $display("ERROR: %s burst gave %0d of %0d strobes within %0d cycles",
               name, strobes, NUM_TRANS, BURST_LIMIT);
      timeout_errors++;
    end
    repeat (QUIET_GAP) step();                // The unselected generator finishes too.
  endtask

  // ~~~ Test sequence ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    int unsigned total;
    int          waited;
    rst_n          = 1'b0;
    host_wr        = '0;
    cfg            = '{cycle: IDX_W'(CYCLE), freq_div: CNT_W'(FREQ_DIV),
                       sound_speed: SPEED_W'(SPEED)};
    mode           = MODE_GAIN;
    update         = 1'b0;
    lfsr_q         = 16'd83;
    timeout_errors = 0;
    test_name      = "reset_hold";
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_name = "load";
    for (int a = 0; a < GAIN_WORDS; a++) begin
      load_gain(a);
    end
    for (int a = 0; a < FOCUS_DEPTH; a++) begin
      load_focus(a);
    end

    repeat (3) run_burst(MODE_GAIN, "gain_replay");
    repeat (3) run_burst(MODE_FOCUS, "focus_phase");

    wait_for_idx(5);                          // Same pattern through both generators.
    run_burst(MODE_GAIN, "mode_select");
    wait_for_idx(5);
    run_burst(MODE_FOCUS, "mode_select");

    test_name = "host_write";
    load_gain(7 * NUM_TRANS + 3);
    load_focus(7);
    wait_for_idx(7);
    run_burst(MODE_GAIN, "host_write");
    wait_for_idx(7);
    run_burst(MODE_FOCUS, "host_write");

    test_name = "reset_hold";
    mode      = MODE_FOCUS;                   // Reset lands in the middle of a burst.
    update    = 1'b1;
    step();
    update = 1'b0;
    waited = 0;
    while (!dout_valid && waited < BURST_LIMIT) begin
      step();
      waited++;
    end
    rst_n = 1'b0;
    repeat (3) step();
    rst_n = 1'b1;
    repeat (2 * FREQ_DIV) step();             // The time base restarts from zero.

    total = stm_checker_i.value_errors + stm_checker_i.protocol_errors + timeout_errors;
    $display("Errors: value %0d, protocol %0d, timeout %0d",
             stm_checker_i.value_errors, stm_checker_i.protocol_errors, timeout_errors);
    if (total == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("ERROR: watchdog expired after %0d cycles before the run completed",
             WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- verification/stm_checker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Watches the STM engine ports, predicts every strobe and the
// sequence index, and counts mismatches for the testbench.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
module stm_checker
  import stm_pkg::*;
(
  input logic             clk,
  input logic             rst_n,
  input stm_mode_e        mode,
  input logic             update,
  input stm_cfg_t         cfg,
  input drive_t           dout,
  input logic             dout_valid,
  input logic [IDX_W-1:0] idx
);

  int unsigned      value_errors    = 0;
  int unsigned      protocol_errors = 0;
  longint unsigned  cyc             = 0;           // Edges since reset release.
  longint unsigned  upd_cyc         = 0;
  int               seen            = NUM_TRANS;   // Strobes of the current burst.
  logic             in_reset        = 1'b0;
  logic [IDX_W-1:0] burst_idx       = '0;
  stm_mode_e        burst_mode      = MODE_GAIN;

  // ~~~ Reference model ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Floor square root by setting result bits from the top down.
  function automatic longint unsigned isqrt(input longint unsigned s);
    longint unsigned r;
    longint unsigned t;
    r = 0;
    for (int b = 31; b >= 0; b--) begin
      t = r | (64'd1 << b);
      if (t * t <= s) begin
        r = t;
      end
    end
    return r;
  endfunction

  function automatic drive_t expected_drive(input stm_mode_e m, input logic [IDX_W-1:0] i,
                                            input int t, input logic [SPEED_W-1:0] speed);
    gain_word_t      g;
    focus_word_t     f;
    longint unsigned pos;
    longint unsigned dx;
    longint unsigned prod;
    drive_t          d;
    d.trans = TRANS_W'(t);
    if (m == MODE_GAIN) begin
      g       = stm_operator_tb.gain_copy[(int'(i) % GAIN_DEPTH) * NUM_TRANS + t];
      d.duty  = g.duty;
      d.phase = g.phase;
    end else begin
      f    = stm_operator_tb.focus_copy[int'(i) % FOCUS_DEPTH];
      pos  = 64'(t * TRANS_PITCH);                 // Transducers sit on the x axis.
      dx   = (64'(f.x) >= pos) ? 64'(f.x) - pos : pos - 64'(f.x);
      prod = isqrt(dx * dx + 64'(f.y) * 64'(f.y) + 64'(f.z) * 64'(f.z)) * 64'(speed);
      d.duty  = f.duty;
      d.phase = WIDTH'(prod >> PHASE_SHIFT);
    end
    return d;
  endfunction

  // ~~~ Port monitor ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk) begin
    drive_t           exp_drive;
    logic [IDX_W-1:0] exp_idx;
    if (!rst_n) begin
      if (in_reset && (idx !== '0 || dout_valid !== 1'b0)) begin
        $display("ERROR: reset_hold: idx is %0d and dout_valid is %b while reset is held",
                 idx, dout_valid);
        protocol_errors++;
      end
      in_reset = 1'b1;                              // The first reset edge sees old values.
      cyc      = 0;
      seen     = NUM_TRANS;
    end else begin
      in_reset = 1'b0;
      exp_idx  = IDX_W'((cyc / cfg.freq_div) % cfg.cycle);
      if (idx !== exp_idx) begin
        $display("FAIL sampler_step cycle %0d: expected %0d, actual %0d", cyc, exp_idx, idx);
        value_errors++;
      end
      if (dout_valid) begin
        if (seen >= NUM_TRANS) begin
          $display("ERROR: %s: dout_valid strobe with no burst in flight",
                   stm_operator_tb.test_name);
          protocol_errors++;
        end else begin
          exp_drive = expected_drive(burst_mode, burst_idx, seen, cfg.sound_speed);
          if (dout !== exp_drive) begin
            // Each triple is duty, phase and transducer.
            $display("FAIL %s idx %0d: expected d/p/t %0d/%0d/%0d, actual d/p/t %0d/%0d/%0d",
                     stm_operator_tb.test_name, burst_idx, exp_drive.duty, exp_drive.phase,
                     exp_drive.trans, dout.duty, dout.phase, dout.trans);
            value_errors++;
          end
          // Gain words leave on fixed cycles after the update.
          if (burst_mode == MODE_GAIN && cyc != upd_cyc + 64'(2 + seen)) begin
            $display("ERROR: %s: strobe %0d came %0d cycles after update instead of %0d",
                     stm_operator_tb.test_name, seen, cyc - upd_cyc, 2 + seen);
            protocol_errors++;
          end
          seen++;
        end
      end
      if (update) begin
        if (seen < NUM_TRANS) begin
          $display("ERROR: %s: update arrived while a burst was still in flight",
                   stm_operator_tb.test_name);
          protocol_errors++;
        end
        burst_idx  = idx;                           // Value latched by the generators.
        burst_mode = mode;
        upd_cyc    = cyc;
        seen       = 0;
      end
      cyc++;
    end
  end

endmodule

//--- logic/stm_operator.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// STM engine top. Pattern memory, time base and both
// generators; mode picks which stream reaches the outputs.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
module stm_operator
  import stm_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  host_wr_t         host_wr,
  input  stm_cfg_t         cfg,
  input  stm_mode_e        mode,
  input  logic             update,
  output drive_t           dout,
  output logic             dout_valid,
  output logic [IDX_W-1:0] idx
);

  logic [ADDR_W-1:0] gain_addr;
  logic [ADDR_W-1:0] focus_addr;
  gain_word_t        gain_rdata;
  focus_word_t       focus_rdata;
  drive_t            gain_dout;
  drive_t            focus_dout;
  logic              gain_valid;
  logic              focus_valid;

  stm_memory stm_memory_i (
    .clk         (clk),
    .host_wr     (host_wr),
    .gain_addr   (gain_addr),
    .gain_rdata  (gain_rdata),
    .focus_addr  (focus_addr),
    .focus_rdata (focus_rdata)
  );

  stm_sampler stm_sampler_i (
    .clk   (clk),
    .rst_n (rst_n),
    .cfg   (cfg),
    .idx   (idx)
  );

  // Both generators see every update. Only the selected one is forwarded.
  stm_gain_operator stm_gain_operator_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .update     (update),
    .idx        (idx),
    .rd_addr    (gain_addr),
    .rd_data    (gain_rdata),
    .dout       (gain_dout),
    .dout_valid (gain_valid)
  );

  stm_focus_operator stm_focus_operator_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .update     (update),
    .idx        (idx),
    .cfg        (cfg),
    .rd_addr    (focus_addr),
    .rd_data    (focus_rdata),
    .dout       (focus_dout),
    .dout_valid (focus_valid)
  );

  assign dout       = (mode == MODE_GAIN) ? gain_dout  : focus_dout;
  assign dout_valid = (mode == MODE_GAIN) ? gain_valid : focus_valid;

endmodule

//--- logic/stm_focus_operator.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Focus generator. Per transducer, takes the distance to the
// stored focal point by integer square root, then the phase.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
module stm_focus_operator
  import stm_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              update,
  input  logic [IDX_W-1:0]  idx,
  input  stm_cfg_t          cfg,
  output logic [ADDR_W-1:0] rd_addr,
  input  focus_word_t       rd_data,
  output drive_t            dout,
  output logic              dout_valid
);

  focus_state_e             state;
  logic [FOCUS_IDX_W-1:0]   idx_q;
  logic [TRANS_W-1:0]       trans_cnt;
  logic [ITER_W-1:0]        iter;
  logic [WIDTH-1:0]         duty_q;
  logic [SQ_W-1:0]          radicand;
  logic [DIST_W+1:0]        rem;
  logic [DIST_W-1:0]        root;
  logic [COORD_W-1:0]       pos;
  logic [COORD_W-1:0]       dx;
  logic [SQ_W-1:0]          dx_sq;
  logic [SQ_W-1:0]          dy_sq;
  logic [SQ_W-1:0]          dz_sq;
  logic [DIST_W+1:0]        rem_shift;
  logic [DIST_W+1:0]        trial;
  logic [DIST_W+SPEED_W-1:0] speed_prod;

  // The address is presented in F_IDLE so the word is ready in F_READ.
  assign rd_addr = (state == F_IDLE) ? ADDR_W'(idx % FOCUS_DEPTH) : ADDR_W'(idx_q);

  // ~~~ Squared distance ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign pos   = COORD_W'(trans_cnt * TRANS_PITCH);   // Transducers sit on the x axis.
  assign dx    = (rd_data.x >= pos) ? rd_data.x - pos : pos - rd_data.x;
  assign dx_sq = dx * dx;
  assign dy_sq = rd_data.y * rd_data.y;
  assign dz_sq = rd_data.z * rd_data.z;

  // One restoring step of the square root consumes two radicand bits.
  assign rem_shift  = {rem[DIST_W-1:0], radicand[SQ_W-1 -: 2]};
  assign trial      = {root, 2'b01};
  assign speed_prod = root * cfg.sound_speed;

  // ~~~ Control FSM ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= F_IDLE;
      trans_cnt  <= '0;
      iter       <= '0;
      dout_valid <= 1'b0;
    end else begin
      dout_valid <= 1'b0;
      case (state)
        F_IDLE: if (update) begin
          trans_cnt <= '0;
          state     <= F_READ;
        end
        F_READ: begin
          iter  <= '0;
          state <= F_SQRT;
        end
        F_SQRT: begin
          iter <= iter + 1'b1;
          if (iter == ITER_W'(DIST_W - 1)) begin
            state <= F_EMIT;
          end
        end
        default: begin
          dout_valid <= 1'b1;
          if (trans_cnt == TRANS_W'(NUM_TRANS - 1)) begin
            state <= F_IDLE;
          end else begin
            trans_cnt <= trans_cnt + 1'b1;
            state     <= F_READ;                  // Next transducer.
          end
        end
      endcase
    end
  end

  // ~~~ Datapath ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (state == F_IDLE && update) begin
      idx_q <= FOCUS_IDX_W'(idx % FOCUS_DEPTH);
    end
    if (state == F_READ) begin
      duty_q   <= rd_data.duty;
      radicand <= dx_sq + dy_sq + dz_sq;
      rem      <= '0;
      root     <= '0;
    end else if (state == F_SQRT) begin
      radicand <= radicand << 2;
      if (rem_shift >= trial) begin
        rem  <= rem_shift - trial;
        root <= {root[DIST_W-2:0], 1'b1};
      end else begin
        rem  <= rem_shift;
        root <= {root[DIST_W-2:0], 1'b0};
      end
    end
    if (state == F_EMIT) begin
      dout <= '{duty: duty_q, phase: speed_prod[PHASE_SHIFT +: WIDTH], trans: trans_cnt};
    end
  end

  a_update_when_idle : assert property (
    @(posedge clk) disable iff (!rst_n) update |-> state == F_IDLE
  );

endmodule

//--- logic/stm_gain_operator.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Gain replay. On update, streams the stored duty/phase words
// of the latched pattern, one transducer per cycle.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
module stm_gain_operator
  import stm_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              update,
  input  logic [IDX_W-1:0]  idx,
  output logic [ADDR_W-1:0] rd_addr,
  input  gain_word_t        rd_data,
  output drive_t            dout,
  output logic              dout_valid
);

  logic [GAIN_IDX_W-1:0] base_q;      // Latched pattern number.
  logic [TRANS_W-1:0]    trans_cnt;   // Transducer being addressed.
  logic [TRANS_W-1:0]    trans_q;     // Transducer whose word is on rd_data.
  logic                  active;
  logic                  valid_q;

  assign rd_addr = ADDR_W'(base_q * NUM_TRANS + trans_cnt);

  // ~~~ Sweep control ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active    <= 1'b0;
      trans_cnt <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= active;                      // Tracks the read latency.
      if (update && !active) begin
        active    <= 1'b1;
        trans_cnt <= '0;
      end else if (active) begin
        trans_cnt <= trans_cnt + 1'b1;
        if (trans_cnt == TRANS_W'(NUM_TRANS - 1)) begin
          active <= 1'b0;
        end
      end
    end
  end

  // Pattern number and transducer tag ride alongside the read.
  always_ff @(posedge clk) begin
    if (update && !active) begin
      base_q <= GAIN_IDX_W'(idx % GAIN_DEPTH);
    end
    trans_q <= trans_cnt;
  end

  assign dout       = '{duty: rd_data.duty, phase: rd_data.phase, trans: trans_q};
  assign dout_valid = valid_q;

  a_no_update_in_burst : assert property (
    @(posedge clk) disable iff (!rst_n) update |-> !active
  );

endmodule

//--- logic/stm_sampler.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sequence time base. Steps idx every freq_div clock cycles
// and wraps it at cycle.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
module stm_sampler
  import stm_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  stm_cfg_t         cfg,
  output logic [IDX_W-1:0] idx
);

  logic [CNT_W-1:0] tick;   // Cycles since the last step.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tick <= '0;
      idx  <= '0;
    end else if (tick == cfg.freq_div - 1'b1) begin
      tick <= '0;
      if (idx == cfg.cycle - 1'b1) begin
        idx <= '0;            // End of the sequence.
      end else begin
        idx <= idx + 1'b1;
      end
    end else begin
      tick <= tick + 1'b1;
    end
  end

  // A zero divider or cycle length would stall or never wrap.
  a_cfg_nonzero : assert property (
    @(posedge clk) disable iff (!rst_n)
      (cfg.freq_div != '0) && (cfg.cycle != '0)
  );

endmodule

//--- logic/stm_memory.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pattern store with a gain bank and a focus bank.
// One host write port, one registered read port per bank.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
module stm_memory
  import stm_pkg::*;
(
  input  logic              clk,
  input  host_wr_t          host_wr,
  input  logic [ADDR_W-1:0] gain_addr,
  output gain_word_t        gain_rdata,
  input  logic [ADDR_W-1:0] focus_addr,
  output focus_word_t       focus_rdata
);

  gain_word_t  gain_ram  [GAIN_WORDS];
  focus_word_t focus_ram [FOCUS_DEPTH];

  // ~~~ Host writes ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (host_wr.wr && host_wr.bank == MODE_GAIN) begin
      gain_ram[host_wr.addr[GAIN_ADDR_W-1:0]] <=
        gain_word_t'(host_wr.data[$bits(gain_word_t)-1:0]);
    end
    if (host_wr.wr && host_wr.bank == MODE_FOCUS) begin
      focus_ram[host_wr.addr[FOCUS_IDX_W-1:0]] <=
        focus_word_t'(host_wr.data[$bits(focus_word_t)-1:0]);
    end
  end

  // ~~~ Read ports ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    gain_rdata  <= gain_ram[gain_addr[GAIN_ADDR_W-1:0]];     // One cycle of latency.
    focus_rdata <= focus_ram[focus_addr[FOCUS_IDX_W-1:0]];
  end

  // A write outside its bank would silently alias onto a low address.
  a_wr_in_range : assert property (
    @(posedge clk) host_wr.wr |->
      ((host_wr.bank == MODE_GAIN) ? (host_wr.addr < GAIN_WORDS)
                                   : (host_wr.addr < FOCUS_DEPTH))
  );

endmodule

//--- logic/stm_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Constants, enums and packed structs of the STM engine.
// Modules pull them in by a wildcard import in their header.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package stm_pkg;

  // ~~~ Array geometry and pattern banks ~~~~~~~~~~~~~~~~~~~~~~
  localparam int WIDTH       = 9;                        // Duty and phase width.
  localparam int NUM_TRANS   = 8;                        // Transducers in the line.
  localparam int TRANS_PITCH = 100;                      // Spacing in coordinate units.
  localparam int TRANS_W     = $clog2(NUM_TRANS);
  localparam int GAIN_DEPTH  = 16;                       // Stored gain patterns.
  localparam int GAIN_IDX_W  = $clog2(GAIN_DEPTH);
  localparam int GAIN_WORDS  = GAIN_DEPTH * NUM_TRANS;   // One word per transducer.
  localparam int GAIN_ADDR_W = $clog2(GAIN_WORDS);
  localparam int FOCUS_DEPTH = 64;                       // Stored focal points.
  localparam int FOCUS_IDX_W = $clog2(FOCUS_DEPTH);

  // ~~~ Focus datapath ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int COORD_W     = 12;
  localparam int DIST_W      = 14;                       // Square root result width.
  localparam int SQ_W        = 2 * DIST_W;               // Radicand width.
  localparam int ITER_W      = $clog2(DIST_W);
  localparam int PHASE_SHIFT = 8;
  localparam int SPEED_W     = 32;

  // Host side and time base.
  localparam int IDX_W  = 16;
  localparam int ADDR_W = 16;
  localparam int DATA_W = 48;
  localparam int CNT_W  = 32;

  typedef enum logic {MODE_FOCUS, MODE_GAIN} stm_mode_e;

  typedef enum logic [1:0] {F_IDLE, F_READ, F_SQRT, F_EMIT} focus_state_e;

  typedef struct packed {
    logic [WIDTH-1:0] duty;
    logic [WIDTH-1:0] phase;
  } gain_word_t;

  typedef struct packed {
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
    logic [COORD_W-1:0] z;
    logic [WIDTH-1:0]   duty;
  } focus_word_t;

  typedef struct packed {
    logic              wr;     // Write strobe.
    stm_mode_e         bank;   // Selects the target bank.
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } host_wr_t;

  typedef struct packed {
    logic [IDX_W-1:0]   cycle;
    logic [CNT_W-1:0]   freq_div;
    logic [SPEED_W-1:0] sound_speed;
  } stm_cfg_t;

  typedef struct packed {
    logic [WIDTH-1:0]   duty;
    logic [WIDTH-1:0]   phase;
    logic [TRANS_W-1:0] trans;
  } drive_t;

endpackage
